/* project.f */
rtl/cart_pkg.sv
rtl/rom_write_bridge.sv
rtl/header_region_scan.sv
rtl/quirk_table.sv
rtl/region_select.sv
rtl/cheat_code_loader.sv
rtl/cart_loader_top.sv
testbench/cart_loader_props.sv
testbench/cart_loader_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cartridge loader simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module cart_loader_tb \
	-f project.f \
	-o sim_cart_loader

./obj_dir/sim_cart_loader > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi

echo "Simulation finished without failures"

/* testbench/cart_loader_tb.sv */
/*
 * Cartridge loader testbench
 * Directed tests against a ROM responder with random acknowledge delays
 */
`timescale 1ns/1ps

module cart_loader_tb
	import cart_pkg::*;
();

	localparam int CLK_PERIOD = 4;
	// ROM, header, file index, quirk and cheat words
	localparam int TOTAL_WORDS = 32 + 4 * 8 * 3 + 5 + 8 * 6 + 8;
	localparam int WORD_TIMEOUT = 20;

	logic              clk_sys;
	logic              rst_n;
	logic              download;
	logic [7:0]        index;
	load_bus_t         load;
	logic              rom_we_ack;
	auto_region_e      auto_mode;
	region_prio_e      prio;
	logic              load_wait;
	logic              rom_we_req;
	logic [ADDR_W-1:0] rom_addr;
	logic [DATA_W-1:0] rom_data;
	logic [ADDR_W-1:0] rom_size;
	region_e           region_req;
	logic              region_set;
	quirk_flags_t      quirks;
	gg_code_t          gg_code;
	logic              gg_valid;
	logic              gg_reset;

	int                errors;
	int                checks;
	int                valid_count;
	int                req_toggles;
	logic              req_prev;
	logic              dl_prev;
	int                delay;
	logic [ADDR_W-1:0] mem_addr_q [$];
	logic [DATA_W-1:0] mem_data_q [$];

	cart_loader_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	////////////////////////////////////////
	// ROM responder
	////////////////////////////////////////
	initial begin
		rom_we_ack = 1'b0;
		dl_prev    = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (!(download && dl_prev && index != 8'hFF)) begin
				// Back to idle so a new download starts with both sides at 0
				if (rom_we_ack) begin
					@(posedge clk_sys);
					#1 rom_we_ack = 1'b0;
				end
			end else if (rom_we_req != rom_we_ack) begin
				mem_addr_q.push_back(rom_addr);
				mem_data_q.push_back(rom_data);
				delay = int'($urandom % 5) + 1;
				repeat (delay) @(posedge clk_sys);
				#1 rom_we_ack = rom_we_req;
			end
			dl_prev = download;
		end
	end

	// Counts cheat record pulses and ROM request toggles
	initial begin
		valid_count = 0;
		req_toggles = 0;
		req_prev    = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (gg_valid)
				valid_count++;
			if (rom_we_req != req_prev)
				req_toggles++;
			req_prev = rom_we_req;
		end
	end

	initial begin
		#(TOTAL_WORDS * 10 * CLK_PERIOD);
		$display("Timeout: tests still running after %0d ns", TOTAL_WORDS * 10 * CLK_PERIOD);
		$display("Something failed");
		$finish;
	end

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check(input bit ok, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			$display("Mismatch at %0t: %s", $time, msg);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		$display("Test %s: %s", name, (errors == err_before) ? "passed" : "failed");
	endtask

	task automatic start_download(input logic [7:0] idx);
		index    = idx;
		download = 1'b1;
		tick();
	endtask

	task automatic end_download();
		download = 1'b0;
		tick();
		tick();
	endtask

	// One host word, then hold off while memory is busy
	task automatic send_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		int n;
		n         = 0;
		load.wr   = 1'b1;
		load.addr = addr;
		load.data = data;
		tick();
		load.wr = 1'b0;
		while (load_wait && n < WORD_TIMEOUT) begin
			tick();
			n++;
		end
		assert (!load_wait) else begin
			errors++;
			$display("Memory never acknowledged the write to address %h", addr);
		end
	endtask

	function automatic region_e expected_region(input region_prio_e p, input logic j,
			input logic u, input logic e);
		case (p)
			PRIO_US_EU_JP: return u ? REGION_US : e ? REGION_EU : j ? REGION_JP : REGION_US;
			PRIO_EU_US_JP: return e ? REGION_EU : u ? REGION_US : j ? REGION_JP : REGION_EU;
			PRIO_US_JP_EU: return u ? REGION_US : j ? REGION_JP : e ? REGION_EU : REGION_US;
			default:       return j ? REGION_JP : u ? REGION_US : e ? REGION_EU : REGION_JP;
		endcase
	endfunction

	task automatic test_rom_path();
		int                err_before;
		int                i;
		logic [DATA_W-1:0] words [32];
		err_before = errors;
		mem_addr_q.delete();
		mem_data_q.delete();
		auto_mode = AUTO_OFF;
		start_download(8'h01);
		for (i = 0; i < 32; i++) begin
			words[i] = DATA_W'($urandom);
			send_word(ADDR_W'(2 * i), words[i]);
		end
		end_download();
		check(mem_addr_q.size() == 32, $sformatf("memory saw %0d writes", mem_addr_q.size()));
		for (i = 0; i < 32 && i < mem_addr_q.size(); i++) begin
			check(mem_addr_q[i] == ADDR_W'(2 * i), $sformatf("write %0d at %h", i, mem_addr_q[i]));
			check(mem_data_q[i] == {words[i][7:0], words[i][15:8]},
				$sformatf("write %0d data %h from word %h", i, mem_data_q[i], words[i]));
		end
		check(rom_size == ADDR_W'(62), $sformatf("rom_size %h, expected 3e", rom_size));
		report_test("rom_path", err_before);
	endtask

	task automatic test_header_region();
		int      err_before;
		int      p;
		int      c;
		logic    j;
		logic    u;
		logic    e;
		region_e exp;
		err_before = errors;
		auto_mode  = AUTO_HEADER;
		for (p = 0; p < 4; p++) begin
			prio = region_prio_e'(p);
			for (c = 0; c < 8; c++) begin
				j   = c[2];
				u   = c[1];
				e   = c[0];
				exp = expected_region(prio, j, u, e);
				start_download(8'h00);
				send_word(HDR_REGION_ADDR_0, {(j ? "J" : " "), (u ? "U" : " ")});
				// High byte at 0x1F2 must be ignored
				send_word(HDR_REGION_ADDR_1, {"J", (e ? "E" : " ")});
				send_word(HDR_DONE_ADDR, 16'h0000);
				check(region_set == 1'b1, $sformatf("prio %0d flags %03b without region_set", p, c));
				check(region_req == exp, $sformatf("prio %0d flags %03b gave region %0d, expected %0d",
					p, c, region_req, exp));
				end_download();
				check(region_set == 1'b0, "region_set still high after the download");
			end
		end
		report_test("header_region", err_before);
	endtask

	task automatic test_file_ext();
		int         err_before;
		int         k;
		logic [7:0] idx_list [4];
		err_before = errors;
		idx_list   = '{8'h00, 8'h41, 8'h82, 8'h05};
		auto_mode  = AUTO_FILE_EXT;
		for (k = 0; k < 4; k++) begin
			start_download(idx_list[k]);
			send_word(HDR_DONE_ADDR, 16'h0000);
			check(region_set == (idx_list[k] != 8'h00),
				$sformatf("index %h gave region_set %0b", idx_list[k], region_set));
			check(region_req == idx_list[k][7:6],
				$sformatf("index %h gave region %0d", idx_list[k], region_req));
			end_download();
		end
		auto_mode = AUTO_OFF;
		start_download(8'h41);
		send_word(HDR_DONE_ADDR, 16'h0000);
		tick();
		check(region_set == 1'b0, "region_set high in off mode");
		end_download();
		report_test("file_ext_off", err_before);
	endtask

	task automatic test_quirks();
		int           err_before;
		int           k;
		logic [63:0]  s;
		quirk_flags_t exp;
		logic [63:0]  serials [8];
		err_before = errors;
		serials    = '{"T-081276", "MK-1215 ", "T-113016", "T-89016 ",
			"T-574023", "MK-1229 ", "T-35036 ", "T-99999 "};
		for (k = 0; k < 8; k++) begin
			s   = serials[k];
			// Last entry is not in the table
			exp = (k < 7) ? quirk_flags_t'(7'b1000000 >> k) : quirk_flags_t'('0);
			start_download(8'h01);
			check(quirks == '0, $sformatf("flags %b not cleared by a new download", quirks));
			send_word(SERIAL_FIRST, {s[63:56], 8'h00});
			send_word(SERIAL_FIRST + ADDR_W'(2), s[55:40]);
			send_word(SERIAL_FIRST + ADDR_W'(4), s[39:24]);
			send_word(SERIAL_FIRST + ADDR_W'(6), s[23:8]);
			send_word(SERIAL_FIRST + ADDR_W'(8), {8'h00, s[7:0]});
			send_word(SERIAL_MATCH, 16'h0000);
			check(quirks == exp, $sformatf("serial %s gave flags %b, expected %b", s, quirks, exp));
			end_download();
		end
		report_test("quirks", err_before);
	endtask

	task automatic test_cheat();
		int                err_before;
		int                k;
		int                valid_before;
		int                toggles_before;
		logic [DATA_W-1:0] w [8];
		gg_code_t          exp;
		err_before = errors;
		for (k = 0; k < 8; k++)
			w[k] = DATA_W'($urandom);
		exp.flags      = {w[1], w[0]};
		exp.address    = {w[3], w[2]};
		exp.compare    = {w[5], w[4]};
		exp.replace    = {w[7], w[6]};
		valid_before   = valid_count;
		toggles_before = req_toggles;
		start_download(8'hFF);
		for (k = 0; k < 8; k++) begin
			send_word(ADDR_W'(2 * k), w[k]);
			if (k == 0)
				check(gg_reset == 1'b1, "gg_reset did not pulse after the write to address 0");
			if (k == 7) begin
				check(gg_valid == 1'b1, "gg_valid did not follow the last word");
				check(gg_code == exp, $sformatf("gg_code %h, expected %h", gg_code, exp));
			end
		end
		tick();
		check(gg_valid == 1'b0, "gg_valid longer than one cycle");
		end_download();
		check(valid_count == valid_before + 1, $sformatf("%0d gg_valid pulses",
			valid_count - valid_before));
		check(req_toggles == toggles_before, $sformatf("rom_we_req toggled %0d times",
			req_toggles - toggles_before));
		report_test("cheat_code", err_before);
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////
	initial begin
		void'($urandom(42));
		errors    = 0;
		checks    = 0;
		rst_n     = 1'b0;
		download  = 1'b0;
		index     = 8'h00;
		load      = '0;
		auto_mode = AUTO_OFF;
		prio      = PRIO_US_EU_JP;
		repeat (4) @(posedge clk_sys);
		#1 rst_n = 1'b1;
		tick();
		test_rom_path();
		test_header_region();
		test_file_ext();
		test_quirks();
		test_cheat();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* testbench/cart_loader_props.sv */
/*
 * Cartridge loader protocol properties
 * Host back-pressure, cheat pulse width and region hold in off mode
 */
`timescale 1ns/1ps

module cart_loader_props
	import cart_pkg::*;
(
	input logic         clk_sys,
	input logic         rst_n,
	input load_bus_t    load,
	input logic         load_wait,
	input logic         gg_valid,
	input logic         region_set,
	input auto_region_e auto_mode
);

	// Host holds off while memory is busy
	wr_respects_wait: assert property (@(posedge clk_sys) disable iff (!rst_n)
		load_wait |-> !load.wr)
		else $error("Host wrote while load_wait was high");

	gg_valid_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		gg_valid |=> !gg_valid)
		else $error("gg_valid high for two cycles in a row");

	region_hold_off: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(auto_mode == AUTO_OFF) |-> !$rose(region_set))
		else $error("region_set rose in off mode");

endmodule

bind cart_loader_top cart_loader_props u_props (
	.clk_sys(clk_sys),
	.rst_n(rst_n),
	.load(load),
	.load_wait(load_wait),
	.gg_valid(gg_valid),
	.region_set(region_set),
	.auto_mode(auto_mode)
);

/* rtl/cart_loader_top.sv */
/*
 * Cartridge loader top level
 * Splits host downloads into cartridge and cheat streams and wires the blocks
 */
`timescale 1ns/1ps

module cart_loader_top
	import cart_pkg::*;
#(
	parameter int ADDR_W = cart_pkg::ADDR_W,
	parameter int DATA_W = cart_pkg::DATA_W
) (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              download,
	input  logic [7:0]        index,
	input  load_bus_t         load,
	input  logic              rom_we_ack,
	input  auto_region_e      auto_mode,
	input  region_prio_e      prio,
	output logic              load_wait,
	output logic              rom_we_req,
	output logic [ADDR_W-1:0] rom_addr,
	output logic [DATA_W-1:0] rom_data,
	output logic [ADDR_W-1:0] rom_size,
	output region_e           region_req,
	output logic              region_set,
	output quirk_flags_t      quirks,
	output gg_code_t          gg_code,
	output logic              gg_valid,
	output logic              gg_reset
);

	logic       cart_active;
	logic       code_active;
	logic       hdr_ready;
	hdr_flags_t hdr;

	// All-ones index marks a cheat download
	assign cart_active = download & ~(&index);
	assign code_active = download & (&index);

	rom_write_bridge #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_rom_bridge (
		.clk_sys, .rst_n, .cart_active, .load, .rom_we_ack,
		.load_wait, .rom_we_req, .rom_addr, .rom_data, .rom_size
	);

	header_region_scan u_hdr_scan (
		.clk_sys, .rst_n, .cart_active, .load, .hdr, .hdr_ready
	);

	quirk_table u_quirks (
		.clk_sys, .rst_n, .cart_active, .load, .quirks
	);

	region_select u_region (
		.clk_sys, .rst_n, .hdr, .hdr_ready, .index, .auto_mode, .prio,
		.region_req, .region_set
	);

	cheat_code_loader u_cheats (
		.clk_sys, .rst_n, .code_active, .load, .gg_code, .gg_valid, .gg_reset
	);

endmodule

/* rtl/cheat_code_loader.sv */
/*
 * Cheat code loader
 * Fills a 128-bit code record from eight 16-bit writes
 */
`timescale 1ns/1ps

module cheat_code_loader
	import cart_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst_n,
	input  logic      code_active,
	input  load_bus_t load,
	output gg_code_t  gg_code,
	output logic      gg_valid,
	output logic      gg_reset
);

	logic wr_code;

	assign wr_code = load.wr & code_active;

	// Low half of each field comes first
	always_ff @(posedge clk_sys) begin
		if (wr_code) begin
			case (load.addr[3:0])
				4'd0:  gg_code.flags[15:0]    <= load.data;
				4'd2:  gg_code.flags[31:16]   <= load.data;
				4'd4:  gg_code.address[15:0]  <= load.data;
				4'd6:  gg_code.address[31:16] <= load.data;
				4'd8:  gg_code.compare[15:0]  <= load.data;
				4'd10: gg_code.compare[31:16] <= load.data;
				4'd12: gg_code.replace[15:0]  <= load.data;
				4'd14: gg_code.replace[31:16] <= load.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			gg_valid <= 1'b0;
			gg_reset <= 1'b0;
		end else begin
			// Record complete with the last replace word
			gg_valid <= wr_code && (load.addr[3:0] == 4'd14);
			// Address zero starts a new code list
			gg_reset <= wr_code && (load.addr == '0);
		end
	end

endmodule

/* rtl/region_select.sv */
/*
 * Region select
 * Picks the console region from header flags or file index when the header completes
 */
`timescale 1ns/1ps

module region_select
	import cart_pkg::*;
(
	input  logic         clk_sys,
	input  logic         rst_n,
	input  hdr_flags_t   hdr,
	input  logic         hdr_ready,
	input  logic [7:0]   index,
	input  auto_region_e auto_mode,
	input  region_prio_e prio,
	output region_e      region_req,
	output logic         region_set
);

	logic ready_d;
	logic ready_rise;
	logic ready_fall;

	function automatic logic flagged(input region_e r, input hdr_flags_t h);
		case (r)
			REGION_JP: return h.j;
			REGION_US: return h.u;
			default:   return h.e;
		endcase
	endfunction

	// First flagged region in the order, else the order's first
	function automatic region_e resolve(input region_prio_e p, input hdr_flags_t h);
		region_e ord [3];
		case (p)
			PRIO_US_EU_JP: ord = '{REGION_US, REGION_EU, REGION_JP};
			PRIO_EU_US_JP: ord = '{REGION_EU, REGION_US, REGION_JP};
			PRIO_US_JP_EU: ord = '{REGION_US, REGION_JP, REGION_EU};
			default:       ord = '{REGION_JP, REGION_US, REGION_EU};
		endcase
		if (flagged(ord[0], h))
			return ord[0];
		else if (flagged(ord[1], h))
			return ord[1];
		else if (flagged(ord[2], h))
			return ord[2];
		return ord[0];
	endfunction

	assign ready_rise = hdr_ready & ~ready_d;
	assign ready_fall = ~hdr_ready & ready_d;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ready_d    <= 1'b0;
			region_req <= REGION_JP;
			region_set <= 1'b0;
		end else begin
			ready_d <= hdr_ready;
			if (ready_rise) begin
				case (auto_mode)
					AUTO_HEADER: begin
						region_set <= 1'b1;
						region_req <= resolve(prio, hdr);
					end
					AUTO_FILE_EXT: begin
						region_set <= |index;
						region_req <= region_e'(index[7:6]);
					end
					default: ;
				endcase
			end
			if (ready_fall)
				region_set <= 1'b0;
		end
	end

endmodule

/* rtl/quirk_table.sv */
/*
 * Quirk table
 * Builds the cartridge serial from header writes and matches known titles
 */
`timescale 1ns/1ps

module quirk_table
	import cart_pkg::*;
(
	input  logic         clk_sys,
	input  logic         rst_n,
	input  logic         cart_active,
	input  load_bus_t    load,
	output quirk_flags_t quirks
);

	logic         cart_d;
	logic         cart_rise;
	logic         wr_cart;
	logic         match_wr;
	logic [63:0]  serial;
	quirk_flags_t hit;

	assign cart_rise = cart_active & ~cart_d;
	assign wr_cart   = load.wr & cart_active;
	assign match_wr  = wr_cart && (load.addr == SERIAL_MATCH);

	////////////////////////////////////////
	// Serial assembly, eight ASCII chars
	////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (wr_cart) begin
			case (load.addr)
				SERIAL_FIRST:     serial[63:56] <= load.data[15:8];
				SERIAL_FIRST + 2: serial[55:40] <= load.data;
				SERIAL_FIRST + 4: serial[39:24] <= load.data;
				SERIAL_FIRST + 6: serial[23:8]  <= load.data;
				SERIAL_FIRST + 8: serial[7:0]   <= load.data[7:0];
				default: ;
			endcase
		end
	end

	// One known title per quirk
	always_comb begin
		hit        = '0;
		hit.sram   = (serial == "T-081276");
		hit.eeprom = (serial == "MK-1215 ");
		hit.noram  = (serial == "T-113016");
		hit.fifo   = (serial == "T-89016 ");
		hit.pier   = (serial == "T-574023");
		hit.svp    = (serial == "MK-1229 ");
		hit.fmbusy = (serial == "T-35036 ");
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cart_d <= 1'b0;
			quirks <= '0;
		end else begin
			cart_d <= cart_active;
			if (cart_rise)
				quirks <= '0;
			else if (match_wr)
				quirks <= quirks | hit;
		end
	end

endmodule

/* rtl/header_region_scan.sv */
/*
 * Header region scan
 * Collects region letters at 0x1F0/0x1F2 and flags the end of the header
 */
`timescale 1ns/1ps

module header_region_scan
	import cart_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       cart_active,
	input  load_bus_t  load,
	output hdr_flags_t hdr,
	output logic       hdr_ready
);

	logic       cart_d;
	logic       cart_rise;
	logic       cart_fall;
	logic       wr_cart;
	hdr_flags_t seen;

	// One letter maps to one flag
	function automatic hdr_flags_t classify(input logic [7:0] ch);
		hdr_flags_t f;
		f = '0;
		if (ch == "J")
			f.j = 1'b1;
		else if (ch == "U")
			f.u = 1'b1;
		else if (ch >= "0" && ch <= "Z")
			f.e = 1'b1;
		return f;
	endfunction

	assign cart_rise = cart_active & ~cart_d;
	assign cart_fall = ~cart_active & cart_d;
	assign wr_cart   = load.wr & cart_active;

	always_comb begin
		seen = '0;
		if (wr_cart && load.addr == HDR_REGION_ADDR_0)
			seen = classify(load.data[15:8]) | classify(load.data[7:0]);
		else if (wr_cart && load.addr == HDR_REGION_ADDR_1)
			seen = classify(load.data[7:0]);
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cart_d    <= 1'b0;
			hdr       <= '0;
			hdr_ready <= 1'b0;
		end else begin
			cart_d <= cart_active;
			// Sticky flags, cleared as a new image starts
			hdr <= (cart_rise ? hdr_flags_t'('0) : hdr) | seen;
			if (cart_fall)
				hdr_ready <= 1'b0;
			else if (wr_cart && load.addr == HDR_DONE_ADDR)
				hdr_ready <= 1'b1;
		end
	end

endmodule

/* rtl/rom_write_bridge.sv */
/*
 * ROM write bridge
 * Byte-swaps cartridge words onto a two-phase toggle handshake and holds the host off
 */
`timescale 1ns/1ps

module rom_write_bridge
	import cart_pkg::*;
#(
	parameter int ADDR_W = cart_pkg::ADDR_W,
	parameter int DATA_W = cart_pkg::DATA_W
) (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              cart_active,
	input  load_bus_t         load,
	input  logic              rom_we_ack,
	output logic              load_wait,
	output logic              rom_we_req,
	output logic [ADDR_W-1:0] rom_addr,
	output logic [DATA_W-1:0] rom_data,
	output logic [ADDR_W-1:0] rom_size
);

	logic cart_d;
	logic cart_rise;
	logic cart_fall;
	logic wr_accept;

	assign cart_rise = cart_active & ~cart_d;
	assign cart_fall = ~cart_active & cart_d;

	// Handshake restarts from zero on a new download
	assign wr_accept = load.wr & cart_active & ~cart_rise;

	////////////////////////////////////////
	// Handshake and wait flag
	////////////////////////////////////////
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cart_d     <= 1'b0;
			rom_we_req <= 1'b0;
			load_wait  <= 1'b0;
			rom_size   <= '0;
		end else begin
			cart_d <= cart_active;
			if (cart_rise) begin
				rom_we_req <= 1'b0;
				load_wait  <= 1'b0;
			end else if (wr_accept) begin
				rom_we_req <= ~rom_we_req;
				load_wait  <= 1'b1;
			end else if (load_wait && (rom_we_req == rom_we_ack)) begin
				// Memory has caught up with the last toggle
				load_wait <= 1'b0;
			end

			// Last accepted address is the image size
			if (cart_fall) begin
				rom_size  <= rom_addr;
				load_wait <= 1'b0;
			end
		end
	end

	// Address and swapped data change together with the toggle
	always_ff @(posedge clk_sys) begin
		if (wr_accept) begin
			rom_addr <= ADDR_W'(load.addr);
			rom_data <= DATA_W'({load.data[7:0], load.data[15:8]});
		end
	end

endmodule

/* rtl/cart_pkg.sv */
/*
 * Cartridge loader shared types
 * Load bus, region and quirk encodings, cheat record and header addresses
 */
package cart_pkg;

	// Default load bus widths
	localparam int ADDR_W = 25;
	localparam int DATA_W = 16;

	// One host write, wr is a single cycle strobe
	typedef struct packed {
		logic              wr;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} load_bus_t;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_e;

	typedef enum logic [1:0] {
		AUTO_FILE_EXT = 2'd0,
		AUTO_HEADER   = 2'd1,
		AUTO_OFF      = 2'd2
	} auto_region_e;

	typedef enum logic [1:0] {
		PRIO_US_EU_JP = 2'd0,
		PRIO_EU_US_JP = 2'd1,
		PRIO_US_JP_EU = 2'd2,
		PRIO_JP_US_EU = 2'd3
	} region_prio_e;

	// Region letters seen in the header
	typedef struct packed {
		logic j;
		logic u;
		logic e;
	} hdr_flags_t;

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic noram;
		logic fifo;
		logic pier;
		logic svp;
		logic fmbusy;
	} quirk_flags_t;

	// Cheat record, flags in the top word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} gg_code_t;

	////////////////////////////////////////
	// Header byte addresses
	////////////////////////////////////////
	localparam logic [ADDR_W-1:0] HDR_REGION_ADDR_0 = 'h1F0;
	localparam logic [ADDR_W-1:0] HDR_REGION_ADDR_1 = 'h1F2;
	localparam logic [ADDR_W-1:0] HDR_DONE_ADDR     = 'h200;
	localparam logic [ADDR_W-1:0] SERIAL_FIRST      = 'h182;
	localparam logic [ADDR_W-1:0] SERIAL_MATCH      = 'h18C;

endpackage
